//--- hdl/lane_pkg.sv
package lane_pkg;

    // Positions, speeds and spin share one unsigned word
    localparam int WORD_W = 16;

    // Lane geometry in mm
    localparam logic [WORD_W-1:0] LANE_LENGTH = 1800;
    localparam logic [WORD_W-1:0] PIN_START   = 1000;  // Lane end to the first pin row
    localparam logic [WORD_W-1:0] LANE_CENTER = 300;   // Ball release x

    // Motion constants, all applied once per clock step
    localparam logic [WORD_W-1:0] FRICTION   = 5;
    localparam logic [WORD_W-1:0] TIME_STEP  = 1;
    localparam logic [WORD_W-1:0] SPIN_SCALE = 1000;
    // Integer division, so this rounds down to zero at the current friction
    localparam logic [WORD_W-1:0] SPIN_DECAY = FRICTION * TIME_STEP / 10;

    // Contact distance between ball centre and pin centre
    localparam logic [WORD_W-1:0] BALL_RADIUS = 100;
    localparam logic [WORD_W-1:0] PIN_RADIUS  = 60;
    localparam logic [WORD_W-1:0] HIT_RADIUS  = BALL_RADIUS + PIN_RADIUS;

    localparam int NUM_PINS = 10;

    // Pin spots, index 0 is the head pin
    // Row 1: pin 1, row 2: pins 2-3, row 3: pins 4-6, row 4: pins 7-10
    localparam logic [WORD_W-1:0] PIN_X [NUM_PINS] = '{
        300,
        250, 350,
        200, 300, 400,
        150, 250, 350, 450
    };

    localparam logic [WORD_W-1:0] PIN_Y [NUM_PINS] = '{
        1000,
        1150, 1150,
        1300, 1300, 1300,
        1450, 1450, 1450, 1450
    };

endpackage

//--- hdl/score_pkg.sv
package score_pkg;

    localparam int FRAME_W = 4;   // Frame number 1 to 10
    localparam int COUNT_W = 4;   // Pins knocked in one roll
    localparam int TOTAL_W = 7;   // Raw pin total, at most 100

    // Game limits
    localparam logic [FRAME_W-1:0] NUM_FRAMES = 10;
    localparam logic [COUNT_W-1:0] FRAME_PINS = 10;  // Pins racked per frame

endpackage

//--- hdl/ball_if.sv
`timescale 1ns/1ps

// Ball state from the physics block to the pin deck
interface ball_if;

    logic [lane_pkg::WORD_W-1:0] ball_x;
    logic [lane_pkg::WORD_W-1:0] ball_y;
    logic [lane_pkg::WORD_W-1:0] speed_x;
    logic [lane_pkg::WORD_W-1:0] speed_y;
    logic                        check_collision;  // Ball is inside the pin area
    logic                        rolling;
    logic                        roll_done;        // One cycle after the ball leaves

    modport physics (
        output ball_x, ball_y, speed_x, speed_y,
        output check_collision, rolling, roll_done
    );

    modport deck (
        input ball_x, ball_y, speed_x, speed_y,
        input check_collision, rolling, roll_done
    );

endinterface

//--- hdl/ball_physics.sv
`timescale 1ns/1ps

module ball_physics (
    input  logic                        clk_in,
    input  logic                        rst_in,
    input  logic                        valid_in,
    input  logic [lane_pkg::WORD_W-1:0] initial_speed_x,
    input  logic [lane_pkg::WORD_W-1:0] initial_speed_y,
    input  logic [lane_pkg::WORD_W-1:0] initial_spin,
    input  logic                        enable,
    ball_if.physics                     ball
);

    logic [lane_pkg::WORD_W-1:0] spin;
    logic                        start;
    logic                        at_end;
    logic                        done_q;  // Deck reports the roll in this cycle

    // No launch while a roll, its done pulse or the deck report is in flight
    assign start  = valid_in && enable && !ball.rolling && !ball.roll_done && !done_q;
    assign at_end = ball.ball_y >= lane_pkg::LANE_LENGTH;

    // Contact window covers the pin area during step cycles only
    assign ball.check_collision = ball.rolling && !at_end &&
                                  (ball.ball_y > lane_pkg::LANE_LENGTH - lane_pkg::PIN_START);

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            ball.ball_x    <= '0;
            ball.ball_y    <= '0;
            ball.speed_x   <= '0;
            ball.speed_y   <= '0;
            spin           <= '0;
            ball.rolling   <= 1'b0;
            ball.roll_done <= 1'b0;
            done_q         <= 1'b0;
        end else begin
            ball.roll_done <= 1'b0;
            done_q         <= ball.roll_done;

            if (start) begin
                ball.ball_x  <= lane_pkg::LANE_CENTER;
                ball.ball_y  <= '0;
                ball.speed_x <= initial_speed_x;
                // Same floor of 1 that friction keeps
                ball.speed_y <= (initial_speed_y == '0) ? 1 : initial_speed_y;
                spin         <= initial_spin;
                ball.rolling <= 1'b1;
            end else if (ball.rolling) begin
                if (at_end) begin
                    // Ball has left the lane
                    ball.speed_x   <= '0;
                    ball.speed_y   <= '0;
                    spin           <= '0;
                    ball.rolling   <= 1'b0;
                    ball.roll_done <= 1'b1;
                end else begin
                    if (ball.speed_y > lane_pkg::FRICTION * lane_pkg::TIME_STEP) begin
                        ball.speed_y <= ball.speed_y - lane_pkg::FRICTION * lane_pkg::TIME_STEP;
                    end else begin
                        ball.speed_y <= 1;  // Ball keeps creeping forward
                    end

                    // Spin bends the lateral speed, then slowly wears off
                    ball.speed_x <= ball.speed_x +
                                    (spin * lane_pkg::TIME_STEP) / lane_pkg::SPIN_SCALE;
                    spin         <= spin - lane_pkg::SPIN_DECAY;

                    // Position moves with the speeds of this step
                    ball.ball_x <= ball.ball_x +
                                   (ball.speed_x * lane_pkg::TIME_STEP) / lane_pkg::SPIN_SCALE;
                    ball.ball_y <= ball.ball_y + ball.speed_y * lane_pkg::TIME_STEP;
                end
            end
        end
    end

    // The done pulse only ever comes after rolling has dropped
    a_done_after_roll: assert property (
        @(posedge clk_in) disable iff (rst_in)
        !(ball.roll_done && ball.rolling)
    );

    // A rolling ball always makes forward progress
    a_speed_nonzero: assert property (
        @(posedge clk_in) disable iff (rst_in)
        ball.rolling |-> (ball.speed_y != '0)
    );

endmodule

//--- hdl/pin_deck.sv
`timescale 1ns/1ps

module pin_deck (
    input  logic                          clk_in,
    input  logic                          rst_in,
    ball_if.deck                          ball,
    input  logic                          deck_reset,
    output logic [lane_pkg::NUM_PINS-1:0] pins_standing,
    output logic                          roll_end,
    output logic [score_pkg::COUNT_W-1:0] fallen_count
);

    logic [lane_pkg::NUM_PINS-1:0] hit;
    logic [lane_pkg::NUM_PINS-1:0] pins_next;
    logic [lane_pkg::NUM_PINS-1:0] start_pins;  // Rack as it stood at launch

    function automatic logic [lane_pkg::WORD_W-1:0] abs_diff(
        input logic [lane_pkg::WORD_W-1:0] a,
        input logic [lane_pkg::WORD_W-1:0] b
    );
        return (a >= b) ? a - b : b - a;
    endfunction

    function automatic logic [score_pkg::COUNT_W-1:0] count_ones(
        input logic [lane_pkg::NUM_PINS-1:0] mask
    );
        logic [score_pkg::COUNT_W-1:0] n;
        n = '0;
        for (int i = 0; i < lane_pkg::NUM_PINS; i++) begin
            n = n + {{(score_pkg::COUNT_W-1){1'b0}}, mask[i]};
        end
        return n;
    endfunction

    // Square contact box around each pin spot
    always_comb begin
        for (int i = 0; i < lane_pkg::NUM_PINS; i++) begin
            hit[i] = ball.check_collision &&
                     (abs_diff(ball.ball_x, lane_pkg::PIN_X[i]) <= lane_pkg::HIT_RADIUS) &&
                     (abs_diff(ball.ball_y, lane_pkg::PIN_Y[i]) <= lane_pkg::HIT_RADIUS);
        end
    end

    always_comb begin
        if (deck_reset) begin
            pins_next = '1;  // Fresh rack
        end else begin
            pins_next = pins_standing & ~hit;
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            pins_standing <= '1;
            roll_end      <= 1'b0;
        end else begin
            pins_standing <= pins_next;
            roll_end      <= ball.roll_done;
        end
    end

    // Snapshot tracks the rack between rolls and freezes while the ball is out
    always_ff @(posedge clk_in) begin
        if (!ball.rolling) begin
            start_pins <= pins_next;
        end
        if (ball.roll_done) begin
            fallen_count <= count_ones(start_pins & ~pins_standing);
        end
    end

    // Pins only come back up through a rack reset
    a_no_pin_rises: assert property (
        @(posedge clk_in) disable iff (rst_in)
        !$past(deck_reset) |-> ((pins_standing & ~$past(pins_standing)) == '0)
    );

endmodule

//--- hdl/frame_scorer.sv
`timescale 1ns/1ps

module frame_scorer (
    input  logic                          clk_in,
    input  logic                          rst_in,
    input  logic                          roll_end,
    input  logic [score_pkg::COUNT_W-1:0] fallen_count,
    output logic                          deck_reset,
    output logic [score_pkg::FRAME_W-1:0] frame_num,
    output logic                          roll_in_frame,
    output logic [score_pkg::COUNT_W-1:0] roll_pins,
    output logic                          strike,
    output logic                          spare,
    output logic [score_pkg::TOTAL_W-1:0] total_pins,
    output logic                          score_valid,
    output logic                          game_over
);

    logic [score_pkg::FRAME_W-1:0] cur_frame;   // Frame of the next roll
    logic                          cur_roll;    // 0 first ball, 1 second ball
    logic [score_pkg::COUNT_W-1:0] first_pins;  // Count of the frame's first ball
    logic [score_pkg::COUNT_W:0]   frame_sum;
    logic                          take_roll;
    logic                          is_strike;
    logic                          frame_end;

    assign take_roll = roll_end && !game_over;
    assign frame_sum = cur_roll ? {1'b0, first_pins} + {1'b0, fallen_count}
                                : {1'b0, fallen_count};
    assign is_strike = !cur_roll && (fallen_count == score_pkg::FRAME_PINS);
    assign frame_end = cur_roll || is_strike;

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            cur_frame     <= {{(score_pkg::FRAME_W-1){1'b0}}, 1'b1};
            cur_roll      <= 1'b0;
            first_pins    <= '0;
            frame_num     <= {{(score_pkg::FRAME_W-1){1'b0}}, 1'b1};
            roll_in_frame <= 1'b0;
            roll_pins     <= '0;
            strike        <= 1'b0;
            spare         <= 1'b0;
            total_pins    <= '0;
            score_valid   <= 1'b0;
            deck_reset    <= 1'b0;
            game_over     <= 1'b0;
        end else begin
            score_valid <= 1'b0;
            deck_reset  <= 1'b0;

            if (take_roll) begin
                // Outputs describe the roll just scored
                frame_num     <= cur_frame;
                roll_in_frame <= cur_roll;
                roll_pins     <= fallen_count;
                strike        <= is_strike;
                spare         <= cur_roll && (frame_sum == {1'b0, score_pkg::FRAME_PINS});
                total_pins    <= total_pins +
                                 {{(score_pkg::TOTAL_W-score_pkg::COUNT_W){1'b0}}, fallen_count};
                score_valid   <= 1'b1;

                if (frame_end) begin
                    deck_reset <= 1'b1;
                    cur_roll   <= 1'b0;
                    cur_frame  <= cur_frame + 1'b1;
                    if (cur_frame == score_pkg::NUM_FRAMES) begin
                        game_over <= 1'b1;  // Sticky until reset
                    end
                end else begin
                    cur_roll   <= 1'b1;
                    first_pins <= fallen_count;
                end
            end
        end
    end

    // Deck counts over one frame can never exceed a full rack
    a_frame_pins_max: assert property (
        @(posedge clk_in) disable iff (rst_in)
        take_roll |-> (frame_sum <= {1'b0, score_pkg::FRAME_PINS})
    );

endmodule

//--- hdl/bowling_lane.sv
`timescale 1ns/1ps

module bowling_lane (
    input  logic                          clk_in,
    input  logic                          rst_in,
    input  logic                          valid_in,
    input  logic [lane_pkg::WORD_W-1:0]   initial_speed_x,
    input  logic [lane_pkg::WORD_W-1:0]   initial_speed_y,
    input  logic [lane_pkg::WORD_W-1:0]   initial_spin,
    output logic                          busy,
    output logic [lane_pkg::NUM_PINS-1:0] pins_standing,
    output logic [score_pkg::FRAME_W-1:0] frame_num,
    output logic                          roll_in_frame,
    output logic [score_pkg::COUNT_W-1:0] roll_pins,
    output logic                          strike,
    output logic                          spare,
    output logic [score_pkg::TOTAL_W-1:0] total_pins,
    output logic                          score_valid,
    output logic                          game_over
);

    logic                          roll_end;
    logic [score_pkg::COUNT_W-1:0] fallen_count;
    logic                          deck_reset;
    logic                          enable;

    ball_if u_ball ();

    assign enable = !game_over;  // Lane closes after the last frame
    assign busy   = u_ball.rolling || u_ball.roll_done || roll_end;

    ball_physics u_physics (
        .clk_in          (clk_in),
        .rst_in          (rst_in),
        .valid_in        (valid_in),
        .initial_speed_x (initial_speed_x),
        .initial_speed_y (initial_speed_y),
        .initial_spin    (initial_spin),
        .enable          (enable),
        .ball            (u_ball.physics)
    );

    pin_deck u_deck (
        .clk_in        (clk_in),
        .rst_in        (rst_in),
        .ball          (u_ball.deck),
        .deck_reset    (deck_reset),
        .pins_standing (pins_standing),
        .roll_end      (roll_end),
        .fallen_count  (fallen_count)
    );

    frame_scorer u_scorer (
        .clk_in        (clk_in),
        .rst_in        (rst_in),
        .roll_end      (roll_end),
        .fallen_count  (fallen_count),
        .deck_reset    (deck_reset),
        .frame_num     (frame_num),
        .roll_in_frame (roll_in_frame),
        .roll_pins     (roll_pins),
        .strike        (strike),
        .spare         (spare),
        .total_pins    (total_pins),
        .score_valid   (score_valid),
        .game_over     (game_over)
    );

endmodule

//--- tests/lane_checker.sv
`timescale 1ns/1ps

// Watches the DUT ports, replays each accepted roll and compares the scored result
module lane_checker (
    input  logic                          clk_in,
    input  logic                          rst_in,
    input  logic                          valid_in,
    input  logic [lane_pkg::WORD_W-1:0]   initial_speed_x,
    input  logic [lane_pkg::WORD_W-1:0]   initial_speed_y,
    input  logic [lane_pkg::WORD_W-1:0]   initial_spin,
    input  logic                          busy,
    input  logic [lane_pkg::NUM_PINS-1:0] pins_standing,
    input  logic [score_pkg::FRAME_W-1:0] frame_num,
    input  logic                          roll_in_frame,
    input  logic [score_pkg::COUNT_W-1:0] roll_pins,
    input  logic                          strike,
    input  logic                          spare,
    input  logic [score_pkg::TOTAL_W-1:0] total_pins,
    input  logic                          score_valid,
    input  logic                          game_over,
    output int                            value_errors,
    output int                            protocol_errors,
    output int                            rolls_checked
);

    logic [lane_pkg::NUM_PINS-1:0] model_pins;  // Rack after the roll in flight
    logic [lane_pkg::NUM_PINS-1:0] knocked;
    int                            model_frame;
    int                            model_roll;
    int                            first_count;
    int                            model_total;
    int                            expected_count;
    logic                          model_over;
    logic                          in_flight;

    // Replays the roll one step at a time and returns the pins it knocks down
    function automatic logic [lane_pkg::NUM_PINS-1:0] knocked_pins(
        input logic [lane_pkg::WORD_W-1:0]   vx_start,
        input logic [lane_pkg::WORD_W-1:0]   vy_start,
        input logic [lane_pkg::WORD_W-1:0]   spin_start,
        input logic [lane_pkg::NUM_PINS-1:0] standing
    );
        logic [lane_pkg::WORD_W-1:0]   x, y, vx, vy, s, dx, dy;
        logic [lane_pkg::NUM_PINS-1:0] down;
        int                            steps;
        x     = lane_pkg::LANE_CENTER;
        y     = '0;
        vx    = vx_start;
        vy    = (vy_start == '0) ? 1 : vy_start;
        s     = spin_start;
        down  = '0;
        steps = 0;
        while (y < lane_pkg::LANE_LENGTH && steps < 70000) begin
            if (y > lane_pkg::LANE_LENGTH - lane_pkg::PIN_START) begin
                for (int i = 0; i < lane_pkg::NUM_PINS; i++) begin
                    dx = (x > lane_pkg::PIN_X[i]) ? x - lane_pkg::PIN_X[i] : lane_pkg::PIN_X[i] - x;
                    dy = (y > lane_pkg::PIN_Y[i]) ? y - lane_pkg::PIN_Y[i] : lane_pkg::PIN_Y[i] - y;
                    if (standing[i] && dx <= lane_pkg::HIT_RADIUS && dy <= lane_pkg::HIT_RADIUS) begin
                        down[i] = 1'b1;
                    end
                end
            end
            // Position first, with the speeds the step started with
            x  = x + vx * lane_pkg::TIME_STEP / lane_pkg::SPIN_SCALE;
            y  = y + vy * lane_pkg::TIME_STEP;
            vx = vx + s * lane_pkg::TIME_STEP / lane_pkg::SPIN_SCALE;
            if (vy <= lane_pkg::FRICTION * lane_pkg::TIME_STEP + 1) begin
                vy = 1;
            end else begin
                vy = vy - lane_pkg::FRICTION * lane_pkg::TIME_STEP;
            end
            s     = s - lane_pkg::SPIN_DECAY;
            steps = steps + 1;
        end
        return down;
    endfunction

    task automatic compare_field(input string what, input int got, input int expected);
        if (got != expected) begin
            value_errors++;
            $display("error %0t ns: %s is %0d, expected %0d", $time, what, got, expected);
        end
    endtask

    task automatic score_roll();
        logic exp_strike;
        logic exp_spare;
        logic frame_end;
        exp_strike  = (model_roll == 0) && (expected_count == lane_pkg::NUM_PINS);
        exp_spare   = (model_roll == 1) && (first_count + expected_count == lane_pkg::NUM_PINS);
        frame_end   = exp_strike || (model_roll == 1);
        model_total = model_total + expected_count;
        compare_field("roll_pins", roll_pins, expected_count);
        compare_field("strike", strike, exp_strike);
        compare_field("spare", spare, exp_spare);
        compare_field("total_pins", total_pins, model_total);
        compare_field("frame_num", frame_num, model_frame);
        compare_field("roll_in_frame", roll_in_frame, model_roll);
        compare_field("pins_standing", pins_standing, model_pins);
        if (frame_end) begin
            model_over  = (model_frame == score_pkg::NUM_FRAMES);
            model_frame = model_frame + 1;
            model_roll  = 0;
            model_pins  = '1;  // Fresh rack for the next frame
        end else begin
            first_count = expected_count;
            model_roll  = 1;
        end
        in_flight = 1'b0;
        rolls_checked++;
    endtask

    always @(negedge clk_in) begin
        if (rst_in) begin
            model_pins  = '1;
            model_frame = 1;
            model_roll  = 0;
            first_count = 0;
            model_total = 0;
            model_over  = 1'b0;
            in_flight   = 1'b0;
        end else begin
            if (score_valid && in_flight) begin
                score_roll();
            end else if (score_valid) begin
                protocol_errors++;
                $display("A score_valid pulse came at %0t ns with no roll in flight", $time);
            end
            if (busy !== in_flight) begin
                protocol_errors++;
                $display("busy was %0b at %0t ns but a roll in flight was %0b",
                         busy, $time, in_flight);
            end
            if (game_over !== model_over) begin
                value_errors++;
                $display("error %0t ns: game_over is %0b, expected %0b", $time, game_over, model_over);
            end
            // A pulse seen here is taken at the next rising edge
            if (valid_in && !in_flight && !model_over) begin
                knocked        = knocked_pins(initial_speed_x, initial_speed_y, initial_spin,
                                              model_pins);
                expected_count = $countones(knocked);
                model_pins     = model_pins & ~knocked;
                in_flight      = 1'b1;
            end
        end
    end

endmodule

//--- tests/tb_bowling_lane.sv
`timescale 1ns/1ps

module tb_bowling_lane;

    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 10;
    localparam int DRIVE_DELAY  = 1;
    localparam int MAX_ROLLS    = 24;  // Directed rolls, a full random game and dropped pulses
    // Forward speed never drops below 1, so one roll is at most one step per mm plus a few
    localparam int ROLL_CYCLES  = lane_pkg::LANE_LENGTH + 20;
    localparam int WATCHDOG_NS  = (RESET_CYCLES + MAX_ROLLS * ROLL_CYCLES + 1000) * CLK_PERIOD;
    localparam int ALL_PINS     = (1 << lane_pkg::NUM_PINS) - 1;

    logic                          clk_in;
    logic                          rst_in;
    logic                          valid_in;
    logic [lane_pkg::WORD_W-1:0]   initial_speed_x;
    logic [lane_pkg::WORD_W-1:0]   initial_speed_y;
    logic [lane_pkg::WORD_W-1:0]   initial_spin;
    logic                          busy;
    logic [lane_pkg::NUM_PINS-1:0] pins_standing;
    logic [score_pkg::FRAME_W-1:0] frame_num;
    logic                          roll_in_frame;
    logic [score_pkg::COUNT_W-1:0] roll_pins;
    logic                          strike;
    logic                          spare;
    logic [score_pkg::TOTAL_W-1:0] total_pins;
    logic                          score_valid;
    logic                          game_over;
    int                            value_errors;
    int                            protocol_errors;
    int                            rolls_checked;
    int                            scenario_errors;
    integer                        seed;

    bowling_lane u_dut (.*);

    lane_checker u_chk (.*);  // Same port names as the DUT, plus the error counts

    initial begin
        clk_in = 1'b0;
        forever #(CLK_PERIOD / 2) clk_in = ~clk_in;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    // One-cycle request, driven just after the edge
    task automatic launch_ball(input int vx, input int vy, input int spin);
        @(posedge clk_in);
        #DRIVE_DELAY;
        valid_in        = 1'b1;
        initial_speed_x = vx[lane_pkg::WORD_W-1:0];
        initial_speed_y = vy[lane_pkg::WORD_W-1:0];
        initial_spin    = spin[lane_pkg::WORD_W-1:0];
        @(posedge clk_in);
        #DRIVE_DELAY;
        valid_in = 1'b0;
    endtask

    task automatic wait_score();
        @(negedge clk_in);
        while (!score_valid) begin
            @(negedge clk_in);
        end
    endtask

    // Counts score_valid pulses seen on the DUT port over a number of cycles
    task automatic count_scores(input int cycles, output int pulses);
        pulses = 0;
        repeat (cycles) begin
            @(negedge clk_in);
            if (score_valid) begin
                pulses++;
            end
        end
    endtask

    task automatic bowl(input int vx, input int vy, input int spin);
        launch_ball(vx, vy, spin);
        wait_score();
    endtask

    task automatic expect_value(input string what, input int got, input int expected);
        if (got != expected) begin
            scenario_errors++;
            $display("error %0t ns: %s is %0d, expected %0d", $time, what, got, expected);
        end
    endtask

    initial begin
        int pulses;
        int rolls;
        int rx;
        int ry;
        int rs;
        seed            = 32'hac9b;
        scenario_errors = 0;
        rst_in          = 1'b1;
        valid_in        = 1'b0;
        initial_speed_x = '0;
        initial_speed_y = '0;
        initial_spin    = '0;
        repeat (RESET_CYCLES) @(posedge clk_in);
        #DRIVE_DELAY;
        rst_in = 1'b0;

        // Straight fast ball down the centre clears the rack
        bowl(0, 200, 0);
        expect_value("strike on the centre ball", strike, 1);
        expect_value("roll_pins on the centre ball", roll_pins, lane_pkg::NUM_PINS);
        @(negedge clk_in);
        expect_value("pins_standing after the rack reset", pins_standing, ALL_PINS);

        // Slow ball with lateral speed drifts wide of the pin area
        bowl(1000, 30, 0);
        expect_value("roll_pins on the wide ball", roll_pins, 0);
        expect_value("pins_standing after the wide ball", pins_standing, ALL_PINS);

        // Second ball of frame 2, with a request while it rolls
        launch_ball(0, 400, 0);
        launch_ball(0, 200, 0);  // Lands while busy
        wait_score();
        count_scores(50, pulses);
        expect_value("score_valid pulses after the busy request", pulses, 0);
        expect_value("total_pins after the busy pulse", total_pins, 19);

        // Fast ball skips the head pin, then a second ball takes it for a spare
        bowl(0, 400, 0);
        expect_value("roll_pins on the first ball of frame 3", roll_pins, 9);
        expect_value("pins left after the first ball", pins_standing, 1);
        bowl(0, 200, 0);
        expect_value("roll_pins on the second ball of frame 3", roll_pins, 1);
        expect_value("spare on frame 3", spare, 1);

        // Random launches until the last frame closes the game
        rolls = 0;
        while (!game_over && rolls < MAX_ROLLS) begin
            rx = $unsigned($random(seed)) % 1500;
            ry = 60 + $unsigned($random(seed)) % 200;
            rs = $unsigned($random(seed)) % 2000;
            bowl(rx, ry, rs);
            rolls++;
        end
        expect_value("game_over after the random game", game_over, 1);

        // Lane stays closed after the last frame
        repeat (3) launch_ball(0, 200, 0);
        count_scores(100, pulses);
        expect_value("score_valid pulses after game over", pulses, 0);
        expect_value("game_over held", game_over, 1);
        expect_value("busy after game over", busy, 0);

        $display("Rolls checked %0d, value errors %0d, protocol errors %0d, scenario errors %0d",
                 rolls_checked, value_errors, protocol_errors, scenario_errors);
        if (value_errors + protocol_errors + scenario_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- list.f
hdl/lane_pkg.sv
hdl/score_pkg.sv
hdl/ball_if.sv
hdl/ball_physics.sv
hdl/pin_deck.sv
hdl/frame_scorer.sv
hdl/bowling_lane.sv
tests/lane_checker.sv
tests/tb_bowling_lane.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Compile the testbench and RTL with Verilator, run it and check the log
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f list.f \
    --top-module tb_bowling_lane \
    -o tb_bowling_lane

./obj_dir/tb_bowling_lane | tee sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
    echo "Simulation failed"
    exit 1
fi
echo "Simulation passed"
